// File: decode_stage.sv
`timescale 1ns/10ps

module decode_stage (
    input  logic               clk,
    input  logic               reset,
    input  riscv_pkg::if_id_t  if_id,
    input  logic               imem_stall,
    input  logic               redirect,
    input  riscv_pkg::wb_t     wb,
    output riscv_pkg::id_ex_t  id_ex,
    output logic               load_use_stall
);

    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;

    riscv_pkg::word_t     instr;
    riscv_pkg::word_t     imm;
    riscv_pkg::word_t     rs1_val;
    riscv_pkg::word_t     rs2_val;
    riscv_pkg::reg_addr_t rs1;
    riscv_pkg::reg_addr_t rs2;
    riscv_pkg::instr_id_e instr_id;
    riscv_pkg::id_ex_t    dec;
    logic                 is_r;
    logic                 is_i;

    assign instr = if_id.instr;
    assign rs1   = instr[19:15];
    assign rs2   = instr[24:20];

    register_file u_regs (
        .clk     (clk),
        .reset   (reset),
        .rs1     (rs1),
        .rs2     (rs2),
        .wb      (wb),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val)
    );

    always_comb begin
        instr_id = riscv_pkg::instr_nop;
        case (instr[6:0])
            op_reg: begin
                case ({instr[31:25], instr[14:12]})
                    10'b0000000_000: instr_id = riscv_pkg::instr_add;
                    10'b0100000_000: instr_id = riscv_pkg::instr_sub;
                    10'b0000000_111: instr_id = riscv_pkg::instr_and;
                    10'b0000000_110: instr_id = riscv_pkg::instr_or;
                    10'b0000000_100: instr_id = riscv_pkg::instr_xor;
                    10'b0000000_010: instr_id = riscv_pkg::instr_slt;
                    10'b0000000_001: instr_id = riscv_pkg::instr_sll;
                    10'b0000000_101: instr_id = riscv_pkg::instr_srl;
                    10'b0100000_101: instr_id = riscv_pkg::instr_sra;
                    default: instr_id = riscv_pkg::instr_nop;
                endcase
            end
            op_imm: begin
                case (instr[14:12])
                    3'b000:  instr_id = riscv_pkg::instr_addi;
                    3'b111:  instr_id = riscv_pkg::instr_andi;
                    3'b110:  instr_id = riscv_pkg::instr_ori;
                    3'b100:  instr_id = riscv_pkg::instr_xori;
                    3'b010:  instr_id = riscv_pkg::instr_slti;
                    default: instr_id = riscv_pkg::instr_nop;
                endcase
            end
            op_lui:   instr_id = riscv_pkg::instr_lui;
            op_load:  if (instr[14:12] == 3'b010) instr_id = riscv_pkg::instr_lw;
            op_store: if (instr[14:12] == 3'b010) instr_id = riscv_pkg::instr_sw;
            op_branch: begin
                if (instr[14:12] == 3'b000) instr_id = riscv_pkg::instr_beq;
                if (instr[14:12] == 3'b001) instr_id = riscv_pkg::instr_bne;
            end
            op_jal:   instr_id = riscv_pkg::instr_jal;
            default:  instr_id = riscv_pkg::instr_nop;
        endcase
    end

    // Immediate by format
    always_comb begin
        case (instr[6:0])
            op_imm, op_load: imm = {{20{instr[31]}}, instr[31:20]};
            op_store:  imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            op_branch: imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                              instr[11:8], 1'b0};
            op_lui:    imm = {instr[31:12], 12'b0};
            op_jal:    imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                              instr[30:21], 1'b0};
            default:   imm = '0;
        endcase
    end

    assign is_r = instr_id inside {riscv_pkg::instr_add, riscv_pkg::instr_sub,
                                   riscv_pkg::instr_and, riscv_pkg::instr_or,
                                   riscv_pkg::instr_xor, riscv_pkg::instr_slt,
                                   riscv_pkg::instr_sll, riscv_pkg::instr_srl,
                                   riscv_pkg::instr_sra};
    assign is_i = instr_id inside {riscv_pkg::instr_addi, riscv_pkg::instr_andi,
                                   riscv_pkg::instr_ori, riscv_pkg::instr_xori,
                                   riscv_pkg::instr_slti};

    always_comb begin
        dec              = '0;
        dec.instr_id     = instr_id;
        dec.pc           = if_id.pc;
        dec.rs1_val      = rs1_val;
        dec.rs2_val      = rs2_val;
        dec.imm          = imm;
        dec.rs1          = rs1;
        dec.rs2          = rs2;
        dec.rd           = instr[11:7];
        dec.is_load      = instr_id == riscv_pkg::instr_lw;
        dec.is_store     = instr_id == riscv_pkg::instr_sw;
        dec.is_branch_eq = instr_id == riscv_pkg::instr_beq;
        dec.is_branch_ne = instr_id == riscv_pkg::instr_bne;
        dec.is_jal       = instr_id == riscv_pkg::instr_jal;
        dec.rs1_used     = is_r || is_i || dec.is_load || dec.is_store ||
                           dec.is_branch_eq || dec.is_branch_ne;
        dec.rs2_used     = is_r || dec.is_store || dec.is_branch_eq || dec.is_branch_ne;
        dec.rd_write     = is_r || is_i || dec.is_load || dec.is_jal ||
                           instr_id == riscv_pkg::instr_lui;
        dec.use_imm      = is_i || dec.is_load || dec.is_store ||
                           instr_id == riscv_pkg::instr_lui;
        case (instr_id)
            riscv_pkg::instr_sub:  dec.alu_op = riscv_pkg::alu_sub;
            riscv_pkg::instr_and,
            riscv_pkg::instr_andi: dec.alu_op = riscv_pkg::alu_and;
            riscv_pkg::instr_or,
            riscv_pkg::instr_ori:  dec.alu_op = riscv_pkg::alu_or;
            riscv_pkg::instr_xor,
            riscv_pkg::instr_xori: dec.alu_op = riscv_pkg::alu_xor;
            riscv_pkg::instr_slt,
            riscv_pkg::instr_slti: dec.alu_op = riscv_pkg::alu_slt;
            riscv_pkg::instr_sll:  dec.alu_op = riscv_pkg::alu_sll;
            riscv_pkg::instr_srl:  dec.alu_op = riscv_pkg::alu_srl;
            riscv_pkg::instr_sra:  dec.alu_op = riscv_pkg::alu_sra;
            riscv_pkg::instr_lui:  dec.alu_op = riscv_pkg::alu_pass_b;
            default:               dec.alu_op = riscv_pkg::alu_add;
        endcase
    end

    // Load in execute feeding a source here
    assign load_use_stall = id_ex.instr_id == riscv_pkg::instr_lw && id_ex.rd != '0 &&
                            ((dec.rs1_used && id_ex.rd == rs1) ||
                             (dec.rs2_used && id_ex.rd == rs2));

    // All-zero ID/EX is a bubble
    always_ff @(posedge clk) begin
        if (reset || load_use_stall || imem_stall || redirect) begin
            id_ex <= '0;
        end else begin
            id_ex <= dec;
        end
    end

endmodule

// File: execute_stage.sv
`timescale 1ns/10ps

module execute_stage (
    input  logic                clk,
    input  logic                reset,
    input  riscv_pkg::id_ex_t   id_ex,
    input  riscv_pkg::wb_t      wb,
    output riscv_pkg::ex_mem_t  ex_mem,
    output logic                redirect,
    output riscv_pkg::word_t    redirect_pc
);

    riscv_pkg::word_t op_a;
    riscv_pkg::word_t op_b;
    riscv_pkg::word_t alu_b;
    riscv_pkg::word_t alu_out;
    logic             operands_equal;

    // EX/MEM first, then MEM/WB, then the value read in decode
    function automatic riscv_pkg::word_t fwd_operand(input riscv_pkg::reg_addr_t src,
                                                     input riscv_pkg::word_t decoded);
        if (ex_mem.rd_write && !ex_mem.is_load && ex_mem.rd != '0 && ex_mem.rd == src) begin
            return ex_mem.result;
        end else if (wb.wr_en && wb.rd != '0 && wb.rd == src) begin
            return wb.value;
        end else begin
            return decoded;
        end
    endfunction

    always_comb begin
        op_a = fwd_operand(id_ex.rs1, id_ex.rs1_val);
        op_b = fwd_operand(id_ex.rs2, id_ex.rs2_val);
    end

    assign alu_b = id_ex.use_imm ? id_ex.imm : op_b;

    // Loads and stores use alu_add for rs1 + imm
    always_comb begin
        alu_out = '0;
        case (id_ex.alu_op)
            riscv_pkg::alu_add:    alu_out = op_a + alu_b;
            riscv_pkg::alu_sub:    alu_out = op_a - alu_b;
            riscv_pkg::alu_and:    alu_out = op_a & alu_b;
            riscv_pkg::alu_or:     alu_out = op_a | alu_b;
            riscv_pkg::alu_xor:    alu_out = op_a ^ alu_b;
            riscv_pkg::alu_slt: begin
                alu_out = {{(riscv_pkg::xlen-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
            end
            riscv_pkg::alu_sll:    alu_out = op_a << alu_b[4:0];
            riscv_pkg::alu_srl:    alu_out = op_a >> alu_b[4:0];
            riscv_pkg::alu_sra:    alu_out = riscv_pkg::word_t'($signed(op_a) >>> alu_b[4:0]);
            riscv_pkg::alu_pass_b: alu_out = alu_b;
            default:               alu_out = '0;
        endcase
    end

    // Branches compare the forwarded registers, not the ALU output
    assign operands_equal = op_a == op_b;
    assign redirect = id_ex.is_jal ||
                      (id_ex.is_branch_eq && operands_equal) ||
                      (id_ex.is_branch_ne && !operands_equal);
    assign redirect_pc = id_ex.pc + id_ex.imm;

    always_ff @(posedge clk) begin
        ex_mem.result     <= id_ex.is_jal ? id_ex.pc + 32'd4 : alu_out;
        ex_mem.store_data <= op_b;
        ex_mem.rd         <= id_ex.rd;
        if (reset) begin
            ex_mem.rd_write <= 1'b0;
            ex_mem.is_load  <= 1'b0;
            ex_mem.is_store <= 1'b0;
        end else begin
            ex_mem.rd_write <= id_ex.rd_write;
            ex_mem.is_load  <= id_ex.is_load;
            ex_mem.is_store <= id_ex.is_store;
        end
    end

    // Decode must have inserted a bubble behind the load
    load_use_stalled: assert property (@(posedge clk) disable iff (reset)
        (ex_mem.is_load && ex_mem.rd != '0) |->
            !(id_ex.rs1_used && id_ex.rs1 == ex_mem.rd) &&
            !(id_ex.rs2_used && id_ex.rs2 == ex_mem.rd));

endmodule

// File: fetch_stage.sv
`timescale 1ns/10ps

module fetch_stage #(
    parameter riscv_pkg::word_t reset_pc = '0
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               freeze,
    input  logic               redirect,
    input  riscv_pkg::word_t   redirect_pc,
    output riscv_pkg::word_t   imem_addr,
    input  riscv_pkg::word_t   imem_data,
    output riscv_pkg::if_id_t  if_id
);

    riscv_pkg::word_t pc;

    assign imem_addr = pc;

    // Redirect wins over a freeze
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_pc;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (!freeze) begin
            pc <= pc + 32'd4;
        end
    end

    // IF/ID takes a NOP for the squashed slot
    always_ff @(posedge clk) begin
        if (reset) begin
            if_id.pc    <= reset_pc;
            if_id.instr <= riscv_pkg::nop_instr;
        end else if (redirect) begin
            if_id.instr <= riscv_pkg::nop_instr;
        end else if (!freeze) begin
            if_id.pc    <= pc;
            if_id.instr <= imem_data;
        end
    end

    pc_aligned: assert property (@(posedge clk) disable iff (reset)
        pc[1:0] == 2'b00);

endmodule

// File: memory_stage.sv
`timescale 1ns/10ps

module memory_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  riscv_pkg::ex_mem_t    ex_mem,
    output riscv_pkg::dmem_req_t  dmem_req,
    input  riscv_pkg::word_t      dmem_rdata,
    output riscv_pkg::wb_t        wb
);

    riscv_pkg::word_t     mem_wb_result;
    riscv_pkg::word_t     mem_wb_load_data;
    riscv_pkg::reg_addr_t mem_wb_rd;
    logic                 mem_wb_is_load;
    logic                 mem_wb_wr_en;

    // Single address serves both loads and stores
    assign dmem_req.addr  = ex_mem.result;
    assign dmem_req.wdata = ex_mem.store_data;
    assign dmem_req.wr_en = ex_mem.is_store;
    assign dmem_req.rd_en = ex_mem.is_load;

    always_ff @(posedge clk) begin
        mem_wb_result    <= ex_mem.result;
        mem_wb_load_data <= dmem_rdata;
        mem_wb_rd        <= ex_mem.rd;
        if (reset) begin
            mem_wb_wr_en   <= 1'b0;
            mem_wb_is_load <= 1'b0;
        end else begin
            // Writes to x0 are dropped here
            mem_wb_wr_en   <= ex_mem.rd_write && ex_mem.rd != '0;
            mem_wb_is_load <= ex_mem.is_load;
        end
    end

    assign wb.rd    = mem_wb_rd;
    assign wb.value = mem_wb_is_load ? mem_wb_load_data : mem_wb_result;
    assign wb.wr_en = mem_wb_wr_en;

    dmem_one_op: assert property (@(posedge clk) disable iff (reset)
        !(dmem_req.wr_en && dmem_req.rd_en));

endmodule

// File: register_file.sv
`timescale 1ns/10ps

module register_file (
    input  logic                 clk,
    input  logic                 reset,
    input  riscv_pkg::reg_addr_t rs1,
    input  riscv_pkg::reg_addr_t rs2,
    input  riscv_pkg::wb_t       wb,
    output riscv_pkg::word_t     rs1_val,
    output riscv_pkg::word_t     rs2_val
);

    // x0 has no storage
    riscv_pkg::word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.wr_en && wb.rd != '0) begin
            regs[wb.rd] <= wb.value;
        end
    end

    // Same-cycle writeback passes straight through to decode
    assign rs1_val = (rs1 == '0) ? '0 :
                     (wb.wr_en && wb.rd == rs1) ? wb.value : regs[rs1];
    assign rs2_val = (rs2 == '0) ? '0 :
                     (wb.wr_en && wb.rd == rs2) ? wb.value : regs[rs2];

    // A written register reads back its new value in the next cycle
    read_after_write: assert property (@(posedge clk) disable iff (reset)
        (wb.wr_en && wb.rd != '0) |=>
            (rs1 != $past(wb.rd) || (wb.wr_en && wb.rd == rs1) ||
             rs1_val == $past(wb.value)) &&
            (rs2 != $past(wb.rd) || (wb.wr_en && wb.rd == rs2) ||
             rs2_val == $past(wb.value)));

endmodule

// File: riscv_core.f
riscv_pkg.sv
fetch_stage.sv
register_file.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
riscv_core.sv
riscv_core_tb.sv

// File: riscv_core.sv
`timescale 1ns/10ps

module riscv_core #(
    parameter riscv_pkg::word_t reset_pc = '0
) (
    input  logic                  clk,
    input  logic                  reset,
    output riscv_pkg::word_t      imem_addr,
    input  riscv_pkg::word_t      imem_data,
    input  logic                  imem_stall,
    output riscv_pkg::dmem_req_t  dmem_req,
    input  riscv_pkg::word_t      dmem_rdata
);

    riscv_pkg::if_id_t  if_id;
    riscv_pkg::id_ex_t  id_ex;
    riscv_pkg::ex_mem_t ex_mem;
    riscv_pkg::wb_t     wb;
    riscv_pkg::word_t   redirect_pc;
    logic               redirect;
    logic               load_use_stall;
    logic               freeze;

    // Front end holds on a hazard or an instruction memory stall
    assign freeze = load_use_stall || imem_stall;

    fetch_stage #(
        .reset_pc (reset_pc)
    ) u_fetch (
        .clk         (clk),
        .reset       (reset),
        .freeze      (freeze),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .imem_addr   (imem_addr),
        .imem_data   (imem_data),
        .if_id       (if_id)
    );

    decode_stage u_decode (
        .clk            (clk),
        .reset          (reset),
        .if_id          (if_id),
        .imem_stall     (imem_stall),
        .redirect       (redirect),
        .wb             (wb),
        .id_ex          (id_ex),
        .load_use_stall (load_use_stall)
    );

    execute_stage u_execute (
        .clk         (clk),
        .reset       (reset),
        .id_ex       (id_ex),
        .wb          (wb),
        .ex_mem      (ex_mem),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    memory_stage u_memory (
        .clk        (clk),
        .reset      (reset),
        .ex_mem     (ex_mem),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata),
        .wb         (wb)
    );

endmodule

// File: riscv_core_tb.sv
`timescale 1ns/10ps

module riscv_core_tb;

    localparam int mem_words    = 256;
    localparam int max_steps    = 200;
    // Summed lengths of all programs run below with the rerun included
    localparam int total_instrs = 102;
    localparam int run_limit    = total_instrs * 4 + 100;

    typedef struct packed {
        riscv_pkg::word_t addr;
        riscv_pkg::word_t data;
    } store_t;

    logic                 clk = 1'b0;
    logic                 reset = 1'b1;
    logic                 imem_stall = 1'b0;
    logic                 random_stall = 1'b0;
    riscv_pkg::word_t     imem_addr;
    riscv_pkg::word_t     imem_data;
    riscv_pkg::dmem_req_t dmem_req;
    riscv_pkg::word_t     dmem_rdata;
    riscv_pkg::word_t     imem [mem_words];
    riscv_pkg::word_t     dmem [mem_words];
    riscv_pkg::word_t     prog [$];
    riscv_pkg::word_t     alu_prog [$];
    store_t               expected [$];
    store_t               next_store;
    string                test_name = "reset";
    int                   mismatches = 0;
    int                   other_errors = 0;

    riscv_core #(
        .reset_pc (32'h0)
    ) u_dut (
        .clk        (clk),
        .reset      (reset),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .imem_stall (imem_stall),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata)
    );

    always #10 clk = ~clk;

    assign imem_data  = imem[imem_addr[9:2]];
    // Read data only while the core requests a read
    assign dmem_rdata = dmem_req.rd_en ? dmem[dmem_req.addr[9:2]] : '0;

    always @(posedge clk) begin
        if (!reset && dmem_req.wr_en) begin
            dmem[dmem_req.addr[9:2]] <= dmem_req.wdata;
        end
    end

    always @(negedge clk) begin
        imem_stall = random_stall ? 1'($urandom_range(1, 0)) : 1'b0;
    end

    // Each store sits in EX/MEM for exactly one cycle
    always @(negedge clk) begin
        if (!reset && dmem_req.wr_en) begin
            if (expected.size() == 0) begin
                $display("Extra store to address %h with data %h in %s",
                         dmem_req.addr, dmem_req.wdata, test_name);
                other_errors++;
            end else begin
                next_store = expected.pop_front();
                check_value({test_name, " store address"}, next_store.addr, dmem_req.addr);
                check_value({test_name, " store data"}, next_store.data, dmem_req.wdata);
            end
        end
    end

    initial begin
        repeat (run_limit) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", run_limit);
        $display("TEST FAILED");
        $finish;
    end

    task automatic check_value(input string name, input riscv_pkg::word_t exp_val,
                               input riscv_pkg::word_t act_val);
        if (act_val !== exp_val) begin
            $display("Mismatch in %s: expected %h, actual %h", name, exp_val, act_val);
            mismatches++;
        end
    endtask

    // Fill patterns carry the byte address of each word
    function automatic riscv_pkg::word_t fill_word(input int idx);
        return 32'hc0de_0000 | (idx << 2);
    endfunction

    function automatic riscv_pkg::word_t fill_instr(input int idx);
        // ADDI x0, x0, byte address
        return {12'(idx << 2), 5'd0, 3'b000, 5'd0, 7'b0010011};
    endfunction

    function automatic void reg_alu(input logic [6:0] f7, input logic [2:0] f3,
                                    input int rd, input int rs1, input int rs2);
        prog.push_back({f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011});
    endfunction

    function automatic void imm_alu(input logic [2:0] f3, input int rd, input int rs1,
                                    input int imm);
        prog.push_back({12'(imm), 5'(rs1), f3, 5'(rd), 7'b0010011});
    endfunction

    function automatic void load_upper(input int rd, input int imm);
        prog.push_back({20'(imm), 5'(rd), 7'b0110111});
    endfunction

    function automatic void load_word(input int rd, input int rs1, input int imm);
        prog.push_back({12'(imm), 5'(rs1), 3'b010, 5'(rd), 7'b0000011});
    endfunction

    function automatic void store_word(input int rs2, input int rs1, input int imm);
        logic [11:0] i = 12'(imm);
        prog.push_back({i[11:5], 5'(rs2), 5'(rs1), 3'b010, i[4:0], 7'b0100011});
    endfunction

    function automatic void branch(input logic [2:0] f3, input int rs1, input int rs2,
                                   input int imm);
        logic [12:0] i = 13'(imm);
        prog.push_back({i[12], i[10:5], 5'(rs2), 5'(rs1), f3, i[4:1], i[11], 7'b1100011});
    endfunction

    function automatic void jump_link(input int rd, input int imm);
        logic [20:0] i = 21'(imm);
        prog.push_back({i[20], i[10:1], i[11], i[19:12], 5'(rd), 7'b1101111});
    endfunction

    // LUI plus ADDI with the upper part rounded for the sign of the low 12 bits
    function automatic void load_const(input int rd, input riscv_pkg::word_t value);
        load_upper(rd, (value + 32'h800) >> 12);
        imm_alu(3'b000, rd, rd, value[11:0]);
    endfunction

    function automatic riscv_pkg::word_t alu_ref(input logic alt, input logic [2:0] f3,
                                                 input riscv_pkg::word_t a,
                                                 input riscv_pkg::word_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b100:  return a ^ b;
            3'b101: begin
                if (alt) return riscv_pkg::word_t'($signed(a) >>> b[4:0]);
                return a >> b[4:0];
            end
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // Runs the program one instruction at a time and queues every store
    function automatic void predict_stores();
        riscv_pkg::word_t regs [32];
        riscv_pkg::word_t mem [mem_words];
        riscv_pkg::word_t pc;
        riscv_pkg::word_t next_pc;
        riscv_pkg::word_t ins;
        riscv_pkg::word_t a;
        riscv_pkg::word_t b;
        riscv_pkg::word_t imm;
        riscv_pkg::word_t addr;
        riscv_pkg::word_t res;
        logic             wr;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = fill_word(i);
        end
        pc = '0;
        for (int step = 0; step < max_steps; step++) begin
            ins     = imem[pc[9:2]];
            a       = regs[ins[19:15]];
            b       = regs[ins[24:20]];
            imm     = {{20{ins[31]}}, ins[31:20]};
            res     = '0;
            wr      = 1'b1;
            next_pc = pc + 32'd4;
            case (ins[6:0])
                7'b0110011: res = alu_ref(ins[30], ins[14:12], a, b);
                7'b0010011: res = alu_ref(1'b0, ins[14:12], a, imm);
                7'b0110111: res = {ins[31:12], 12'b0};
                7'b0000011: begin
                    addr = a + imm;
                    res  = mem[addr[9:2]];
                end
                7'b0100011: begin
                    addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    mem[addr[9:2]] = b;
                    expected.push_back({addr, b});
                    wr = 1'b0;
                end
                7'b1100011: begin
                    // funct3 bit 0 turns BEQ into BNE
                    if ((a == b) != ins[12]) begin
                        next_pc = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                    end
                    wr = 1'b0;
                end
                7'b1101111: begin
                    res     = pc + 32'd4;
                    next_pc = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
                end
                default: wr = 1'b0;
            endcase
            if (wr && ins[11:7] != 5'd0) regs[ins[11:7]] = res;
            // Halt is a jump to itself
            if (next_pc == pc) break;
            pc = next_pc;
        end
    endfunction

    task automatic run_program(input string name, input logic stall_on);
        int cycles;
        reset = 1'b1;
        for (int i = 0; i < mem_words; i++) begin
            imem[i] = (i < prog.size()) ? prog[i] : fill_instr(i);
            dmem[i] = fill_word(i);
        end
        expected.delete();
        predict_stores();
        test_name = "reset";
        repeat (5) begin
            @(negedge clk);
            check_value("reset imem_addr", '0, imem_addr);
            check_value("reset dmem wr_en", '0, riscv_pkg::word_t'(dmem_req.wr_en));
            check_value("reset dmem rd_en", '0, riscv_pkg::word_t'(dmem_req.rd_en));
        end
        test_name    = name;
        reset        = 1'b0;
        random_stall = stall_on;
        cycles       = 0;
        // Stores are popped on the falling edge
        while (expected.size() != 0 && cycles < prog.size() * 4 + 20) begin
            @(posedge clk);
            cycles++;
        end
        if (expected.size() != 0) begin
            $display("Missing %0d stores at the end of %s", expected.size(), name);
            other_errors++;
            expected.delete();
        end
        // Extra stores show up in the compare process
        repeat (8) @(negedge clk);
        random_stall = 1'b0;
    endtask

    task automatic alu_chain_test();
        prog.delete();
        load_const(1, $urandom());
        load_const(2, $urandom());
        reg_alu(7'h00, 3'b000, 3, 1, 2);
        reg_alu(7'h20, 3'b000, 4, 3, 1);
        reg_alu(7'h00, 3'b111, 5, 4, 3);
        reg_alu(7'h00, 3'b110, 6, 5, 2);
        reg_alu(7'h00, 3'b100, 7, 6, 4);
        reg_alu(7'h00, 3'b010, 8, 7, 6);
        reg_alu(7'h00, 3'b001, 9, 7, 2);
        reg_alu(7'h00, 3'b101, 10, 9, 1);
        reg_alu(7'h20, 3'b101, 11, 7, 3);
        imm_alu(3'b000, 12, 11, $urandom());
        imm_alu(3'b111, 13, 12, $urandom());
        imm_alu(3'b110, 14, 13, $urandom());
        imm_alu(3'b100, 15, 14, $urandom());
        imm_alu(3'b010, 16, 15, $urandom());
        load_upper(17, $urandom());
        for (int r = 3; r <= 17; r++) begin
            store_word(r, 0, 'h100 + 4 * (r - 3));
        end
        jump_link(0, 0);
        alu_prog = prog;
        run_program("alu_forwarding", 1'b0);
    endtask

    task automatic load_use_test();
        prog.delete();
        load_const(1, $urandom());
        store_word(1, 0, 'h200);
        load_word(2, 0, 'h200);
        reg_alu(7'h00, 3'b000, 3, 2, 1);
        store_word(3, 0, 'h204);
        load_word(4, 0, 'h204);
        store_word(4, 0, 'h208);
        jump_link(0, 0);
        run_program("load_use", 1'b0);
    endtask

    task automatic control_flow_test();
        prog.delete();
        load_const(1, $urandom());
        imm_alu(3'b000, 2, 1, 0);
        branch(3'b000, 1, 2, 12);
        store_word(1, 0, 'h300);
        store_word(2, 0, 'h304);
        branch(3'b001, 1, 2, 12);
        store_word(1, 0, 'h308);
        store_word(2, 0, 'h30c);
        jump_link(5, 12);
        store_word(1, 0, 'h310);
        store_word(1, 0, 'h314);
        store_word(5, 0, 'h318);
        jump_link(0, 0);
        run_program("control_flow", 1'b0);
    endtask

    task automatic x0_test();
        prog.delete();
        load_const(1, $urandom());
        imm_alu(3'b000, 0, 1, 123);
        reg_alu(7'h00, 3'b000, 0, 1, 1);
        load_upper(0, $urandom());
        store_word(0, 0, 'h380);
        reg_alu(7'h00, 3'b000, 2, 0, 0);
        store_word(2, 0, 'h384);
        jump_link(0, 0);
        run_program("x0_writes", 1'b0);
    endtask

    initial begin
        void'($urandom(31588));
        alu_chain_test();
        load_use_test();
        control_flow_test();
        prog = alu_prog;
        run_program("imem_stall", 1'b1);
        x0_test();
        $display("Errors: %0d mismatches, %0d other failures", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: riscv_pkg.sv
package riscv_pkg;

    localparam int xlen = 32;

    typedef logic [4:0] reg_addr_t;
    typedef logic [xlen-1:0] word_t;

    // Kept RV32I subset, anything else decodes as instr_nop
    typedef enum logic [5:0] {
        instr_nop,
        instr_add,
        instr_sub,
        instr_and,
        instr_or,
        instr_xor,
        instr_slt,
        instr_sll,
        instr_srl,
        instr_sra,
        instr_addi,
        instr_andi,
        instr_ori,
        instr_xori,
        instr_slti,
        instr_lui,
        instr_lw,
        instr_sw,
        instr_beq,
        instr_bne,
        instr_jal
    } instr_id_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_pass_b
    } alu_op_e;

    // ADDI x0, x0, 0
    localparam word_t nop_instr = 32'h0000_0013;

    typedef struct packed {
        word_t pc;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        instr_id_e instr_id;
        alu_op_e   alu_op;
        word_t     pc;
        word_t     rs1_val;
        word_t     rs2_val;
        word_t     imm;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        logic      rs1_used;
        logic      rs2_used;
        logic      rd_write;
        logic      is_load;
        logic      is_store;
        logic      is_branch_eq;
        logic      is_branch_ne;
        logic      is_jal;
        logic      use_imm;
    } id_ex_t;

    typedef struct packed {
        word_t     result;
        word_t     store_data;
        reg_addr_t rd;
        logic      rd_write;
        logic      is_load;
        logic      is_store;
    } ex_mem_t;

    typedef struct packed {
        reg_addr_t rd;
        word_t     value;
        logic      wr_en;
    } wb_t;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  wr_en;
        logic  rd_en;
    } dmem_req_t;

endpackage
